// File: build.f
hw/tcu_pkg.sv
hw/tcu_csa_tree.sv
hw/tcu_wallace_mul.sv
hw/tcu_bf16_mul.sv
hw/tcu_dot_reduce.sv
hw/tcu_dot_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_tcu_dot_unit.sv

// File: testbench/tb_tcu_dot_unit.sv
// Testbench for the bf16 dot-product unit
// Directed and random operations, checked against an integer model by assertions

`timescale 1ns/1ps

module tb_tcu_dot_unit
    import tcu_pkg::*;
();

    localparam int NUM_LANES = 4;
    // Top bit of each term before alignment, below sign and headroom
    localparam int TOP_BIT = ACC_W - 5;

    typedef logic [NUM_LANES-1:0][BF16_W-1:0] lanes_t;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    tcu_op_e           op;
    lanes_t            a;
    lanes_t            b;
    logic [FP32_W-1:0] c;
    logic              out_valid;
    logic [FP32_W-1:0] result;

    // Expected results in issue order
    logic [FP32_W-1:0] exp_q [$];
    string             name_q [$];
    // Head of the queue, refreshed on falling edges only
    logic              head_valid = 1'b0;
    logic [FP32_W-1:0] exp_head = '0;
    string             head_name = "none";

    int errors = 0;
    int checks = 0;
    int issued = 0;
    int tests = 0;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (8)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tcu_dot_unit #(
        .NUM_LANES (NUM_LANES)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .c         (c),
        .out_valid (out_valid),
        .result    (result)
    );

    function automatic logic [BF16_W-1:0] make_bf16(input logic s, input int e, input int m);
        return {s, 8'(e), 7'(m)};
    endfunction

    function automatic logic [BF16_W-1:0] rand_bf16(input int lo, input int hi);
        return {1'($urandom_range(1, 0)), 8'($urandom_range(hi, lo)), 7'($urandom_range(127, 0))};
    endfunction

    function automatic logic [FP32_W-1:0] rand_fp32();
        return {1'($urandom_range(1, 0)), 8'($urandom_range(150, 100)), 23'($urandom)};
    endfunction

    // Reference model
    // Exact products, truncating alignment to the max exponent, integer sum
    function automatic logic [FP32_W-1:0] model_dot(input lanes_t av, input lanes_t bv,
                                                    input logic [FP32_W-1:0] cv,
                                                    input tcu_op_e opv);
        longint mag [NUM_LANES+1];
        int     ex [NUM_LANES+1];
        bit     neg [NUM_LANES+1];
        bit     used [NUM_LANES+1];
        int     e_max;
        int     shift;
        int     lead;
        longint sum;
        longint aligned;
        bit     neg_sum;
        logic [22:0] frac;

        for (int i = 0; i < NUM_LANES; i++) begin
            // 16-bit product of the hidden-one significands, top bit at TOP_BIT
            mag[i] = longint'(128 + av[i][6:0]) * longint'(128 + bv[i][6:0]);
            mag[i] = mag[i] << (TOP_BIT - 15);
            ex[i] = int'(av[i][14:7]) + int'(bv[i][14:7]) - 126;
            neg[i] = av[i][15] ^ bv[i][15];
            used[i] = 1'b1;
        end
        // Addend, 24-bit significand on the same scale
        mag[NUM_LANES] = longint'({1'b1, cv[22:0]}) << (TOP_BIT - 23);
        ex[NUM_LANES] = int'(cv[30:23]);
        neg[NUM_LANES] = cv[31];
        used[NUM_LANES] = (opv == OP_DOT_ADD);

        e_max = ex[0];
        for (int i = 1; i <= NUM_LANES; i++) begin
            if (used[i] && (ex[i] > e_max)) begin
                e_max = ex[i];
            end
        end

        sum = 0;
        for (int i = 0; i <= NUM_LANES; i++) begin
            if (used[i]) begin
                shift = e_max - ex[i];
                aligned = (shift >= ACC_W) ? 0 : (mag[i] >> shift);
                sum += neg[i] ? -aligned : aligned;
            end
        end
        if (sum == 0) begin
            return '0;
        end

        neg_sum = (sum < 0);
        if (neg_sum) begin
            sum = -sum;
        end
        lead = 0;
        while ((sum >> (lead + 1)) != 0) begin
            lead++;
        end
        // 23 bits below the leading one, zero filled when short
        if (lead >= 23) begin
            frac = 23'(sum >> (lead - 23));
        end else begin
            frac = 23'(sum << (23 - lead));
        end
        return {neg_sum, 8'(e_max + lead - TOP_BIT), frac};
    endfunction

    function automatic void refresh_head();
        head_valid = (exp_q.size() > 0);
        exp_head = head_valid ? exp_q[0] : '0;
        head_name = head_valid ? name_q[0] : "none";
    endfunction

    task automatic issue_op(input string name, input lanes_t av, input lanes_t bv,
                            input logic [FP32_W-1:0] cv, input tcu_op_e opv,
                            input logic [FP32_W-1:0] expected);
        @(negedge clk);
        in_valid = 1'b1;
        a = av;
        b = bv;
        c = cv;
        op = opv;
        exp_q.push_back(expected);
        name_q.push_back(name);
        issued++;
        refresh_head();
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        refresh_head();
    endtask

    // Idle until every pending result has come out
    task automatic drain_results();
        int n;

        n = 0;
        while ((exp_q.size() != 0) && (n < 10)) begin
            idle_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d results still pending after %0d idle cycles",
                     exp_q.size(), n);
            exp_q.delete();
            name_q.delete();
            refresh_head();
        end
    endtask

    task automatic report_test(input string name, input int chk0, input int err0);
        tests++;
        $display("%-16s checks %0d  errors %0d", name, checks - chk0, errors - err0);
    endtask

    // Each result leaves the queue on the edge where it is checked
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            checks++;
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    a_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (head_valid && (result == exp_head))
    ) else begin
        errors++;
        if (!head_valid) begin
            $display("Error: a result came out with no operation pending");
        end else begin
            $display("Fail %s expected %h actual %h", head_name, exp_head, $sampled(result));
        end
    end

    a_latency_fwd: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> ##2 out_valid
    ) else begin
        errors++;
        $display("Error: no result two cycles after an accepted operation");
    end

    a_latency_back: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 2)
    ) else begin
        errors++;
        $display("Error: out_valid high without an operation two cycles earlier");
    end

    initial begin
        lanes_t            av;
        lanes_t            bv;
        logic [FP32_W-1:0] cv;
        tcu_op_e           opv;
        int                chk0;
        int                err0;
        int                wait_n;

        void'($urandom(32'h54e7));
        in_valid = 1'b0;
        op = OP_DOT;
        a = '0;
        b = '0;
        c = '0;

        wait_n = 0;
        while (!rst_n && (wait_n < 20)) begin
            @(negedge clk);
            wait_n++;
        end
        if (!rst_n) begin
            errors++;
            $display("Error: reset was not released within 20 cycles");
        end

        // 1.5 times 1.5, other lanes cancel or fall below the sum
        chk0 = checks;
        err0 = errors;
        av[0] = make_bf16(1'b0, 127, 64);
        bv[0] = make_bf16(1'b0, 127, 64);
        for (int i = 1; i < NUM_LANES; i++) begin
            bv[i] = make_bf16(1'b0, 126, 0);
            if ((i % 2 == 1) && (i + 1 < NUM_LANES)) begin
                av[i] = make_bf16(1'b0, 127, 32);
            end else if (i % 2 == 0) begin
                av[i] = make_bf16(1'b1, 127, 32);
            end else begin
                // Unpaired lane, aligned away entirely
                av[i] = make_bf16(1'b0, 100, 0);
                bv[i] = make_bf16(1'b0, 100, 0);
            end
        end
        issue_op("exact_products", av, bv, rand_fp32(), OP_DOT, 32'h4010_0000);
        drain_results();
        report_test("exact_products", chk0, err0);

        // Negative lane 0 dominates
        chk0 = checks;
        err0 = errors;
        av[0] = make_bf16(1'b1, 128, 64);
        bv[0] = make_bf16(1'b0, 128, 0);
        for (int i = 1; i < NUM_LANES; i++) begin
            av[i] = make_bf16(1'(i % 2), 127, 16 * i);
            bv[i] = make_bf16(1'b0, 126, 0);
        end
        issue_op("sign_handling", av, bv, '0, OP_DOT, model_dot(av, bv, '0, OP_DOT));
        for (int k = 0; k < 10; k++) begin
            av[0] = make_bf16(1'b1, 140, $urandom_range(127, 0));
            bv[0] = make_bf16(1'b0, 140, $urandom_range(127, 0));
            for (int i = 1; i < NUM_LANES; i++) begin
                av[i] = rand_bf16(100, 120);
                bv[i] = rand_bf16(100, 120);
            end
            cv = rand_fp32();
            opv = tcu_op_e'(k % 2);
            issue_op("sign_handling", av, bv, cv, opv, model_dot(av, bv, cv, opv));
        end
        drain_results();
        report_test("sign_handling", chk0, err0);

        // Lane 1 product exponent d below lane 0
        chk0 = checks;
        err0 = errors;
        for (int d = 0; d <= 30; d++) begin
            av[0] = rand_bf16(130, 130);
            bv[0] = rand_bf16(130, 130);
            av[1] = rand_bf16(130 - d, 130 - d);
            bv[1] = rand_bf16(130, 130);
            for (int i = 2; i < NUM_LANES; i++) begin
                av[i] = rand_bf16(130 - d, 130);
                bv[i] = rand_bf16(130, 130);
            end
            cv = rand_fp32();
            issue_op("alignment", av, bv, cv, OP_DOT, model_dot(av, bv, cv, OP_DOT));
        end
        drain_results();
        report_test("alignment", chk0, err0);

        // Same operands without and with the addend
        chk0 = checks;
        err0 = errors;
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                av[i] = rand_bf16(100, 150);
                bv[i] = rand_bf16(100, 150);
            end
            cv = rand_fp32();
            issue_op("addend", av, bv, cv, OP_DOT, model_dot(av, bv, cv, OP_DOT));
            issue_op("addend", av, bv, cv, OP_DOT_ADD, model_dot(av, bv, cv, OP_DOT_ADD));
        end
        drain_results();
        report_test("addend", chk0, err0);

        // Lane pairs of opposite sign sum to +0
        chk0 = checks;
        err0 = errors;
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if ((i % 2 == 1) && (i > 0)) begin
                    av[i] = av[i-1] ^ 16'h8000;
                    bv[i] = bv[i-1];
                end else if (i + 1 < NUM_LANES) begin
                    av[i] = rand_bf16(140, 150);
                    bv[i] = rand_bf16(140, 150);
                end else begin
                    av[i] = make_bf16(1'b0, 100, 0);
                    bv[i] = make_bf16(1'b0, 100, 0);
                end
            end
            issue_op("cancellation", av, bv, rand_fp32(), OP_DOT, 32'h0000_0000);
        end
        drain_results();
        report_test("cancellation", chk0, err0);

        // Random stream with occasional idle cycles
        chk0 = checks;
        err0 = errors;
        for (int k = 0; k < 200; k++) begin
            if ($urandom_range(3, 0) == 0) begin
                idle_cycle();
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                av[i] = rand_bf16(100, 150);
                bv[i] = rand_bf16(100, 150);
            end
            cv = rand_fp32();
            opv = tcu_op_e'($urandom_range(1, 0));
            issue_op("pipelining", av, bv, cv, opv, model_dot(av, bv, cv, opv));
        end
        drain_results();
        report_test("pipelining", chk0, err0);

        if (checks != issued) begin
            errors++;
            $display("Error: %0d operations issued but %0d results came out", issued, checks);
        end
        $display("Tests %0d  checks %0d  errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset
// Free-running clock, active-low reset held for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: hw/tcu_dot_unit.sv
// bf16 dot-product unit, top level
// Lane multipliers, stage-one register, reduction, two-cycle valid pipeline

`timescale 1ns/1ps

module tcu_dot_unit import tcu_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  tcu_op_e                          op,
    input  logic [NUM_LANES-1:0][BF16_W-1:0] a,
    input  logic [NUM_LANES-1:0][BF16_W-1:0] b,
    input  logic [FP32_W-1:0]                c,
    output logic                             out_valid,
    output logic [FP32_W-1:0]                result
);

    // Multiplier outputs
    logic [NUM_LANES-1:0]             mul_sign;
    logic [NUM_LANES-1:0][EXP_W-1:0]  mul_exp;
    logic [NUM_LANES-1:0][PSIG_W-1:0] mul_sig;

    // Stage one
    logic                             s1_valid;
    tcu_op_e                          s1_op;
    logic [NUM_LANES-1:0]             s1_sign;
    logic [NUM_LANES-1:0][EXP_W-1:0]  s1_exp;
    logic [NUM_LANES-1:0][PSIG_W-1:0] s1_sig;
    logic                             s1_c_sign;
    logic [FP32_EXP_W-1:0]            s1_c_exp;
    logic [FP32_SIG_W-1:0]            s1_c_sig;

    // One exact multiplier per lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        tcu_bf16_mul u_mul (
            .a      (a[i]),
            .b      (b[i]),
            .sign_y (mul_sign[i]),
            .exp_y  (mul_exp[i]),
            .sig_y  (mul_sig[i])
        );
    end

    // Stage-one valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // Stage-one payload, captured with the operation
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_op     <= op;
            s1_sign   <= mul_sign;
            s1_exp    <= mul_exp;
            s1_sig    <= mul_sig;
            s1_c_sign <= c[FP32_W-1];
            s1_c_exp  <= c[FP32_W-2 -: FP32_EXP_W];
            // Hidden one restored, c is assumed normal
            s1_c_sig  <= {1'b1, c[FP32_SIG_W-2:0]};
        end
    end

    tcu_dot_reduce #(
        .NUM_LANES (NUM_LANES)
    ) u_reduce (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s1_valid),
        .op        (s1_op),
        .prod_sign (s1_sign),
        .prod_exp  (s1_exp),
        .prod_sig  (s1_sig),
        .c_sign    (s1_c_sign),
        .c_exp     (s1_c_exp),
        .c_sig     (s1_c_sig),
        .out_valid (out_valid),
        .result    (result)
    );

    // Both pipeline stages start empty
    a_no_early_valid: assert property (
        @(posedge clk) $rose(rst_n) |=> !out_valid
    );

endmodule

// File: hw/tcu_dot_reduce.sv
// Dot-product reduction stage
// Aligns products and addend to the largest exponent, sums, normalizes to fp32

`timescale 1ns/1ps

module tcu_dot_reduce import tcu_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  tcu_op_e                         op,
    input  logic [NUM_LANES-1:0]            prod_sign,
    input  logic [NUM_LANES-1:0][EXP_W-1:0] prod_exp,
    input  logic [NUM_LANES-1:0][PSIG_W-1:0] prod_sig,
    input  logic                            c_sign,
    input  logic [FP32_EXP_W-1:0]           c_exp,
    input  logic [FP32_SIG_W-1:0]           c_sig,
    output logic                            out_valid,
    output logic [FP32_W-1:0]               result
);

    // Products plus the addend
    localparam int NT = NUM_LANES + 1;
    // Bit that holds each term's top bit before alignment
    localparam int TOP = ACC_W - 5;
    localparam int POS_W = $clog2(ACC_W);

    // Per-term exponent, sign, enable and placed magnitude
    logic signed [EXP_W-1:0] term_exp [NT];
    logic [NT-1:0]           term_sign;
    logic [NT-1:0]           term_en;
    logic [ACC_W-1:0]        term_mag [NT];

    logic signed [EXP_W-1:0] exp_max;
    logic [NT-1:0][ACC_W-1:0] term_al;

    logic [ACC_W-1:0]  sum_raw;
    logic [ACC_W-1:0]  sum_mag;
    logic [POS_W-1:0]  lead_pos;
    logic [ACC_W-1:0]  norm_sig;
    logic [EXP_W-1:0]  exp_norm;
    logic [FP32_W-1:0] result_next;

    // Term setup
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            term_exp[i]  = $signed(prod_exp[i]);
            term_sign[i] = prod_sign[i];
            term_en[i]   = 1'b1;
            // Product top bit lands on TOP
            term_mag[i]  = ACC_W'(prod_sig[i]) << (TOP - PSIG_W + 1);
        end
        // Addend exponent field on the same scale as the products
        term_exp[NUM_LANES]  = $signed(EXP_W'(c_exp));
        term_sign[NUM_LANES] = c_sign;
        term_en[NUM_LANES]   = (op == OP_DOT_ADD);
        term_mag[NUM_LANES]  = ACC_W'(c_sig) << (TOP - FP32_SIG_W + 1);
    end

    // Largest exponent over enabled terms
    // Lane 0 always takes part
    always_comb begin
        exp_max = term_exp[0];
        for (int i = 1; i < NT; i++) begin
            if (term_en[i] && (term_exp[i] > exp_max)) begin
                exp_max = term_exp[i];
            end
        end
    end

    // Alignment shifters
    always_comb begin
        logic [EXP_W-1:0] shamt;
        logic [ACC_W-1:0] shifted;

        for (int i = 0; i < NT; i++) begin
            shamt = EXP_W'(exp_max - term_exp[i]);
            // Bits below bit 0 are dropped, large shifts give zero
            shifted = term_mag[i] >> shamt;
            if (!term_en[i]) begin
                term_al[i] = '0;
            end else if (term_sign[i]) begin
                term_al[i] = -shifted;
            end else begin
                term_al[i] = shifted;
            end
        end
    end

    // Two's complement sum of all terms
    tcu_csa_tree #(
        .N (NT),
        .W (ACC_W),
        .S (ACC_W)
    ) u_term_sum (
        .operands (term_al),
        .sum      (sum_raw),
        .cout     ()
    );

    assign sum_mag = sum_raw[ACC_W-1] ? -sum_raw : sum_raw;

    // Leading-one detector, highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < ACC_W; i++) begin
            if (sum_mag[i]) begin
                lead_pos = POS_W'(i);
            end
        end
    end

    // Leading one moved to the top bit
    assign norm_sig = sum_mag << (ACC_W - 1 - lead_pos);

    // Max exponent plus the leading-one offset from TOP
    assign exp_norm = EXP_W'(exp_max) + EXP_W'(lead_pos) - EXP_W'(TOP);

    // Exact zero comes out as +0
    always_comb begin
        if (sum_raw == '0) begin
            result_next = '0;
        end else begin
            result_next = {sum_raw[ACC_W-1],
                           exp_norm[FP32_EXP_W-1:0],
                           norm_sig[ACC_W-2 -: FP32_SIG_W-1]};
        end
    end

    // Result register, updates only on a valid operation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                result <= result_next;
            end
        end
    end

    // Nonzero sum normalized with its leading one on top and no bits lost
    a_norm_top: assert property (
        @(posedge clk) disable iff (!rst_n)
        (in_valid && (sum_raw != '0)) |=>
            $past(norm_sig[ACC_W-1] && ((norm_sig >> (ACC_W - 1 - lead_pos)) == sum_mag))
    );

endmodule

// File: hw/tcu_bf16_mul.sv
// bf16 multiplier
// Product sign, signed biased exponent and raw 16-bit significand, no rounding

`timescale 1ns/1ps

module tcu_bf16_mul import tcu_pkg::*; (
    input  logic [BF16_W-1:0]       a,
    input  logic [BF16_W-1:0]       b,
    output logic                    sign_y,
    output logic signed [EXP_W-1:0] exp_y,
    output logic [PSIG_W-1:0]       sig_y
);

    // Field split
    logic                  sign_a;
    logic                  sign_b;
    logic [BF16_EXP_W-1:0] exp_a;
    logic [BF16_EXP_W-1:0] exp_b;
    logic [BF16_SIG_W-1:0] sig_a;
    logic [BF16_SIG_W-1:0] sig_b;

    // Exponent adder inputs
    logic [2:0][EXP_W-1:0] exp_terms;

    assign sign_a = a[BF16_W-1];
    assign sign_b = b[BF16_W-1];
    assign exp_a  = a[BF16_W-2 -: BF16_EXP_W];
    assign exp_b  = b[BF16_W-2 -: BF16_EXP_W];
    // Normal inputs only, hidden one always set
    assign sig_a  = {1'b1, a[BF16_SIG_W-2:0]};
    assign sig_b  = {1'b1, b[BF16_SIG_W-2:0]};

    assign sign_y = sign_a ^ sign_b;

    // ea + eb - 126, kept signed and full width for alignment
    assign exp_terms = {EXP_W'(exp_a), EXP_W'(exp_b), EXP_BIAS_ADJ};

    tcu_csa_tree #(
        .N (3),
        .W (EXP_W),
        .S (EXP_W)
    ) u_exp_add (
        .operands (exp_terms),
        .sum      (exp_y),
        .cout     ()
    );

    // 8x8 significand product, binary point below the top bit
    tcu_wallace_mul #(
        .N (BF16_SIG_W)
    ) u_sig_mul (
        .a (sig_a),
        .b (sig_b),
        .p (sig_y)
    );

endmodule

// File: hw/tcu_wallace_mul.sv
// Unsigned N by N Wallace-tree multiplier
// Partial products reduced through the carry-save tree

`timescale 1ns/1ps

module tcu_wallace_mul #(
    parameter int N = 8
) (
    input  logic [N-1:0]   a,
    input  logic [N-1:0]   b,
    output logic [2*N-1:0] p
);

    // One partial product per bit of b
    logic [N-1:0][2*N-1:0] pp;

    // Shifted copy of a, masked by b[i]
    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (b[i]) begin
                pp[i] = (2*N)'(a) << i;
            end else begin
                pp[i] = '0;
            end
        end
    end

    // Exact product fits in 2N bits
    // so the tree works at full width and the top carry is always zero
    tcu_csa_tree #(
        .N (N),
        .W (2*N),
        .S (2*N)
    ) u_pp_tree (
        .operands (pp),
        .sum      (p),
        .cout     ()
    );

endmodule

// File: hw/tcu_csa_tree.sv
// Carry-save adder tree
// Reduces N operands with 3:2 compressor rows, then one carry-propagate add

`timescale 1ns/1ps

module tcu_csa_tree #(
    parameter int N = 3,
    parameter int W = 8,
    parameter int S = 10
) (
    input  logic [N-1:0][W-1:0] operands,
    output logic [S-1:0]        sum,
    output logic                cout
);

    // Last two rows into the final adder
    logic [S-1:0] red_a;
    logic [S-1:0] red_b;

    always_comb begin
        logic [S-1:0] row [N+1];
        logic [S-1:0] a0;
        logic [S-1:0] a1;
        logic [S-1:0] a2;
        int           cnt;
        int           nxt;
        int           grp;

        // Spare row stays zero for a single operand
        for (int i = 0; i <= N; i++) begin
            row[i] = '0;
        end
        for (int i = 0; i < N; i++) begin
            row[i] = S'(operands[i]);
        end
        cnt = N;

        // Each level takes 3 rows to 2 until two rows remain
        for (int lvl = 0; lvl < N; lvl++) begin
            if (cnt > 2) begin
                nxt = 0;
                grp = cnt / 3;
                for (int g = 0; g + 2 < N; g += 3) begin
                    if (g + 2 < cnt) begin
                        a0 = row[g];
                        a1 = row[g+1];
                        a2 = row[g+2];
                        // Sum bits stay, carry bits move up one place
                        row[nxt]   = a0 ^ a1 ^ a2;
                        row[nxt+1] = ((a0 & a1) | (a0 & a2) | (a1 & a2)) << 1;
                        nxt += 2;
                    end
                end
                // Rows left over from an incomplete group pass through
                for (int k = 0; k < N; k++) begin
                    if ((k >= grp * 3) && (k < cnt)) begin
                        row[nxt] = row[k];
                        nxt += 1;
                    end
                end
                cnt = nxt;
            end
        end

        red_a = row[0];
        red_b = row[1];
    end

    // Final carry-propagate adder, top carry reported separately
    assign {cout, sum} = {1'b0, red_a} + {1'b0, red_b};

endmodule

// File: hw/tcu_pkg.sv
// Tensor core dot-product package
// Opcode enum and field widths shared by the bf16 dot-product unit

package tcu_pkg;

    // Operation selector
    typedef enum logic {
        OP_DOT     = 1'b0,  // Sum of products only
        OP_DOT_ADD = 1'b1   // Sum of products plus fp32 addend
    } tcu_op_e;

    // bf16 word and its fields
    localparam int BF16_W     = 16;
    localparam int BF16_EXP_W = 8;
    // Significand with hidden one
    localparam int BF16_SIG_W = 8;

    // fp32 word and its fields
    localparam int FP32_W     = 32;
    localparam int FP32_EXP_W = 8;
    // Significand with hidden one restored
    localparam int FP32_SIG_W = 24;

    // Signed working exponent, same width as the exponent sum
    localparam int EXP_W = 10;

    // Raw product significand, value below 2
    localparam int PSIG_W = 16;

    // Bias of -127 plus 1 for the product's binary point
    localparam logic signed [EXP_W-1:0] EXP_BIAS_ADJ = EXP_W'(-126);

    // Alignment and sum field
    // Sign, three headroom bits, aligned significand, guard bits
    localparam int ACC_W = 32;

endpackage
